// ==== source/conv_config.svh ====
// sizes assume power-of-two buffer and FIFO depths; the job must fit the buffers
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// complex samples per line
`define CONV_LANES 4

// width of one real or imaginary part, Q8.8
`define CONV_SAMPLE_W 16
`define CONV_FRAC_BITS 8

// image buffer holds one line per input map
`define CONV_MAX_MAPS 16
`define CONV_MAX_KERNEL_LINES 64

// output lines waiting for the write port
`define CONV_FIFO_DEPTH 4

`define CONV_ADDR_W 32

`endif

// ==== source/conv_pkg.sv ====
// shared types; samples are signed Q8.8 with the real part in the low half
`default_nettype none

package conv_pkg;

  `include "conv_config.svh"

  typedef struct packed {
    logic signed [`CONV_SAMPLE_W-1:0] im;
    logic signed [`CONV_SAMPLE_W-1:0] re;
  } sample_t;

  // lane 0 sits in the low bits
  typedef sample_t [`CONV_LANES-1:0] line_t;

  // per-lane accumulators, wrap on overflow
  typedef struct packed {
    logic signed [2*`CONV_SAMPLE_W-1:0] im;
    logic signed [2*`CONV_SAMPLE_W-1:0] re;
  } acc_t;

  typedef logic [`CONV_ADDR_W-1:0] addr_t;
  typedef logic [7:0] count_t;

  typedef enum logic {TAG_IMAGE = 1'b0, TAG_KERNEL = 1'b1} tag_t;

  typedef enum logic [1:0] {RD_IDLE, RD_IMAGE, RD_KERNEL, RD_WAIT} rd_state_t;

  typedef enum logic [1:0] {EXEC_IDLE, EXEC_RUN, EXEC_DRAIN} exec_state_t;

endpackage

`default_nettype wire

// ==== source/buffer_read_if.sv ====
// buffer reads return data one cycle after the address; loaded is a level per job
`default_nettype none
`timescale 1ns/1ps

`include "conv_config.svh"

interface buffer_read_if;

  logic [$clog2(`CONV_MAX_MAPS)-1:0]         image_addr;
  logic [$clog2(`CONV_MAX_KERNEL_LINES)-1:0] kernel_addr;
  conv_pkg::line_t                           image_line;
  conv_pkg::line_t                           kernel_line;
  logic                                      loaded;

  modport engine (output image_addr, kernel_addr, input image_line, kernel_line, loaded);
  modport loader (input image_addr, kernel_addr, output image_line, kernel_line, loaded);

endinterface

`default_nettype wire

// ==== source/read_requester.sv ====
// num_maps and num_filters must be at least 1; start is ignored while requests are out
`default_nettype none
`timescale 1ns/1ps

module read_requester (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              start,
  input  wire conv_pkg::addr_t   image_base,
  input  wire conv_pkg::addr_t   kernel_base,
  input  wire conv_pkg::addr_t   dest_base,
  input  wire conv_pkg::count_t  num_maps,
  input  wire conv_pkg::count_t  num_filters,
  input  wire logic              rd_req_almostfull,
  output conv_pkg::addr_t        rd_req_addr,
  output conv_pkg::tag_t         rd_req_tag,
  output logic                   rd_req_en,
  output conv_pkg::count_t       job_maps,
  output conv_pkg::count_t       job_filters,
  output conv_pkg::addr_t        job_dest
);

  conv_pkg::rd_state_t state;
  conv_pkg::addr_t     image_base_q;
  conv_pkg::addr_t     kernel_base_q;
  logic [15:0]         kernel_total;
  // requests issued in the current phase
  logic [15:0]         sent;

  // job registers
  always_ff @(posedge clk) begin
    if ((state == conv_pkg::RD_IDLE || state == conv_pkg::RD_WAIT) && start) begin
      image_base_q  <= image_base;
      kernel_base_q <= kernel_base;
      job_dest      <= dest_base;
      job_maps      <= num_maps;
      job_filters   <= num_filters;
      kernel_total  <= num_maps * num_filters;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= conv_pkg::RD_IDLE;
      rd_req_en <= 1'b0;
      sent      <= '0;
    end else begin
      rd_req_en <= 1'b0;
      case (state)
        conv_pkg::RD_IDLE, conv_pkg::RD_WAIT: begin
          if (start) begin
            state <= conv_pkg::RD_IMAGE;
            sent  <= '0;
            // first image line goes out straight from the idle state
            if (!rd_req_almostfull) begin
              rd_req_en   <= 1'b1;
              rd_req_addr <= image_base;
              rd_req_tag  <= conv_pkg::TAG_IMAGE;
              sent        <= 16'd1;
            end
          end
        end
        conv_pkg::RD_IMAGE: begin
          if (sent == {8'd0, job_maps}) begin
            state <= conv_pkg::RD_KERNEL;
            sent  <= '0;
          end else if (!rd_req_almostfull) begin
            rd_req_en   <= 1'b1;
            rd_req_addr <= image_base_q + conv_pkg::addr_t'(sent);
            rd_req_tag  <= conv_pkg::TAG_IMAGE;
            sent        <= sent + 16'd1;
          end
        end
        conv_pkg::RD_KERNEL: begin
          if (sent == kernel_total) begin
            state <= conv_pkg::RD_WAIT;
          end else if (!rd_req_almostfull) begin
            rd_req_en   <= 1'b1;
            rd_req_addr <= kernel_base_q + conv_pkg::addr_t'(sent);
            rd_req_tag  <= conv_pkg::TAG_KERNEL;
            sent        <= sent + 16'd1;
          end
        end
        default: state <= conv_pkg::RD_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/line_loader.sv ====
// responses must arrive in request order per tag; excess lines wrap in the buffers
`default_nettype none
`timescale 1ns/1ps

`include "conv_config.svh"

module line_loader (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              start,
  input  wire logic              rd_rsp_valid,
  input  wire conv_pkg::tag_t    rd_rsp_tag,
  input  wire conv_pkg::line_t   rd_rsp_data,
  input  wire conv_pkg::count_t  job_maps,
  input  wire conv_pkg::count_t  job_filters,
  buffer_read_if.loader          buf_rd
);

  localparam int IMG_AW = $clog2(`CONV_MAX_MAPS);
  localparam int KER_AW = $clog2(`CONV_MAX_KERNEL_LINES);

  conv_pkg::line_t  image_mem [`CONV_MAX_MAPS];
  conv_pkg::line_t  kernel_mem [`CONV_MAX_KERNEL_LINES];
  conv_pkg::count_t image_cnt;
  logic [15:0]      kernel_cnt;
  // set on start, dropped once the job is in
  logic             armed;

  // stored-line counters double as write pointers
  always_ff @(posedge clk) begin
    if (rd_rsp_valid && rd_rsp_tag == conv_pkg::TAG_IMAGE) begin
      image_mem[image_cnt[IMG_AW-1:0]] <= rd_rsp_data;
    end
    if (rd_rsp_valid && rd_rsp_tag == conv_pkg::TAG_KERNEL) begin
      kernel_mem[kernel_cnt[KER_AW-1:0]] <= rd_rsp_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      image_cnt     <= '0;
      kernel_cnt    <= '0;
      armed         <= 1'b0;
      buf_rd.loaded <= 1'b0;
    end else if (start) begin
      image_cnt     <= '0;
      kernel_cnt    <= '0;
      armed         <= 1'b1;
      buf_rd.loaded <= 1'b0;
    end else begin
      if (rd_rsp_valid && rd_rsp_tag == conv_pkg::TAG_IMAGE) begin
        image_cnt <= image_cnt + 8'd1;
      end
      if (rd_rsp_valid && rd_rsp_tag == conv_pkg::TAG_KERNEL) begin
        kernel_cnt <= kernel_cnt + 16'd1;
      end
      if (armed && image_cnt == job_maps && kernel_cnt == job_maps * job_filters) begin
        armed         <= 1'b0;
        buf_rd.loaded <= 1'b1;
      end
    end
  end

  // registered read ports for the engine
  always_ff @(posedge clk) begin
    buf_rd.image_line  <= image_mem[buf_rd.image_addr];
    buf_rd.kernel_line <= kernel_mem[buf_rd.kernel_addr];
  end

endmodule

`default_nettype wire

// ==== source/mac_engine.sv ====
// one map pair per cycle; a filter starts only when the output FIFO has a slot for it
`default_nettype none
`timescale 1ns/1ps

`include "conv_config.svh"

module mac_engine (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic                               start,
  input  wire conv_pkg::count_t                   job_maps,
  input  wire conv_pkg::count_t                   job_filters,
  input  wire logic [$clog2(`CONV_FIFO_DEPTH):0]  fifo_free,
  buffer_read_if.engine                           buf_rd,
  output logic                                    result_valid,
  output conv_pkg::line_t                         result
);

  localparam int FREE_W = $clog2(`CONV_FIFO_DEPTH) + 1;
  localparam int IMG_AW = $clog2(`CONV_MAX_MAPS);
  localparam int KER_AW = $clog2(`CONV_MAX_KERNEL_LINES);
  localparam int LSB    = `CONV_FRAC_BITS;
  localparam int MSB    = `CONV_FRAC_BITS + `CONV_SAMPLE_W - 1;

  conv_pkg::exec_state_t state;
  conv_pkg::count_t      map_idx;
  conv_pkg::count_t      filt_idx;
  logic                  pending;
  logic [FREE_W-1:0]     in_flight;
  logic [15:0]           kernel_addr_full;
  logic                  pair_first;
  logic                  pair_last;
  logic                  issue;

  logic                  s1_valid;
  logic                  s1_first;
  logic                  s1_last;
  logic                  s2_valid;
  logic                  s2_first;
  logic                  s2_last;
  conv_pkg::acc_t        prod [`CONV_LANES];
  conv_pkg::acc_t        acc [`CONV_LANES];
  conv_pkg::acc_t        acc_next [`CONV_LANES];

  assign kernel_addr_full   = filt_idx * job_maps + {8'd0, map_idx};
  assign buf_rd.image_addr  = map_idx[IMG_AW-1:0];
  assign buf_rd.kernel_addr = kernel_addr_full[KER_AW-1:0];

  assign pair_first = (map_idx == '0);
  assign pair_last  = (map_idx == job_maps - 8'd1);
  // credit check only at a filter boundary
  assign issue = (state == conv_pkg::EXEC_RUN) && (!pair_first || fifo_free > in_flight);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= conv_pkg::EXEC_IDLE;
      pending   <= 1'b0;
      in_flight <= '0;
      map_idx   <= '0;
      filt_idx  <= '0;
    end else begin
      if (start) begin
        pending <= 1'b1;
      end
      // results between the last pair and the FIFO
      case ({issue && pair_last, result_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
      case (state)
        conv_pkg::EXEC_IDLE: begin
          if (pending && buf_rd.loaded) begin
            state    <= conv_pkg::EXEC_RUN;
            pending  <= 1'b0;
            map_idx  <= '0;
            filt_idx <= '0;
          end
        end
        conv_pkg::EXEC_RUN: begin
          if (issue && pair_last) begin
            map_idx <= '0;
            if (filt_idx == job_filters - 8'd1) begin
              state <= conv_pkg::EXEC_DRAIN;
            end else begin
              filt_idx <= filt_idx + 8'd1;
            end
          end else if (issue) begin
            map_idx <= map_idx + 8'd1;
          end
        end
        conv_pkg::EXEC_DRAIN: begin
          if (in_flight == '0) begin
            state <= conv_pkg::EXEC_IDLE;
          end
        end
        default: state <= conv_pkg::EXEC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid     <= 1'b0;
      s2_valid     <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      s1_valid     <= issue;
      s2_valid     <= s1_valid;
      result_valid <= s2_valid && s2_last;
    end
  end

  // stage 1 sees buffer data, stage 2 holds the products
  always_ff @(posedge clk) begin
    s1_first <= pair_first;
    s1_last  <= pair_last;
    s2_first <= s1_first;
    s2_last  <= s1_last;
    for (int i = 0; i < `CONV_LANES; i++) begin
      prod[i].re <= buf_rd.image_line[i].re * buf_rd.kernel_line[i].re
                  - buf_rd.image_line[i].im * buf_rd.kernel_line[i].im;
      prod[i].im <= buf_rd.image_line[i].re * buf_rd.kernel_line[i].im
                  + buf_rd.image_line[i].im * buf_rd.kernel_line[i].re;
    end
  end

  always_comb begin
    for (int i = 0; i < `CONV_LANES; i++) begin
      if (s2_first) begin
        acc_next[i] = prod[i];
      end else begin
        acc_next[i].re = acc[i].re + prod[i].re;
        acc_next[i].im = acc[i].im + prod[i].im;
      end
    end
  end

  // back to Q8.8 on the last map of a filter
  always_ff @(posedge clk) begin
    if (s2_valid) begin
      acc <= acc_next;
    end
    for (int i = 0; i < `CONV_LANES; i++) begin
      result[i].re <= acc_next[i].re[MSB:LSB];
      result[i].im <= acc_next[i].im[MSB:LSB];
    end
  end

endmodule

`default_nettype wire

// ==== source/write_requester.sv ====
// relies on the engine credit check; a push into a full FIFO is not guarded
`default_nettype none
`timescale 1ns/1ps

`include "conv_config.svh"

module write_requester (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic                               start,
  input  wire conv_pkg::addr_t                    job_dest,
  input  wire conv_pkg::count_t                   job_filters,
  input  wire logic                               result_valid,
  input  wire conv_pkg::line_t                    result,
  input  wire logic                               wr_req_almostfull,
  output conv_pkg::addr_t                         wr_req_addr,
  output conv_pkg::line_t                         wr_req_data,
  output logic                                    wr_req_en,
  output logic                                    done,
  output logic [$clog2(`CONV_FIFO_DEPTH):0]       fifo_free
);

  localparam int PTR_W  = $clog2(`CONV_FIFO_DEPTH);
  localparam int FREE_W = PTR_W + 1;
  localparam logic [FREE_W-1:0] DEPTH_VAL = `CONV_FIFO_DEPTH;

  conv_pkg::line_t  fifo_mem [`CONV_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [FREE_W-1:0] fifo_count;
  conv_pkg::count_t written;
  logic             busy;
  logic             pop;

  assign pop       = (fifo_count != '0) && !wr_req_almostfull;
  assign fifo_free = DEPTH_VAL - fifo_count;

  always_ff @(posedge clk) begin
    if (result_valid) begin
      fifo_mem[wr_ptr] <= result;
    end
    if (pop) begin
      wr_req_data <= fifo_mem[rd_ptr];
      wr_req_addr <= job_dest + conv_pkg::addr_t'(written);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
      wr_req_en  <= 1'b0;
    end else begin
      wr_req_en <= pop;
      if (result_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({result_valid, pop})
        2'b10:   fifo_count <= fifo_count + 1'b1;
        2'b01:   fifo_count <= fifo_count - 1'b1;
        default: fifo_count <= fifo_count;
      endcase
    end
  end

  // done follows the last write by one cycle and holds until the next start
  always_ff @(posedge clk) begin
    if (reset) begin
      written <= '0;
      busy    <= 1'b0;
      done    <= 1'b0;
    end else if (start) begin
      written <= '0;
      busy    <= 1'b1;
      done    <= 1'b0;
    end else begin
      if (pop) begin
        written <= written + 8'd1;
      end
      if (busy && written == job_filters) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/conv_accel_top.sv ====
// whole job is loaded on chip before compute; inputs are frequency-domain lines
`default_nettype none
`timescale 1ns/1ps

`include "conv_config.svh"

module conv_accel_top (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              start,
  input  wire conv_pkg::addr_t   image_base,
  input  wire conv_pkg::addr_t   kernel_base,
  input  wire conv_pkg::addr_t   dest_base,
  input  wire conv_pkg::count_t  num_maps,
  input  wire conv_pkg::count_t  num_filters,
  output conv_pkg::addr_t        rd_req_addr,
  output conv_pkg::tag_t         rd_req_tag,
  output logic                   rd_req_en,
  input  wire logic              rd_req_almostfull,
  input  wire logic              rd_rsp_valid,
  input  wire conv_pkg::tag_t    rd_rsp_tag,
  input  wire conv_pkg::line_t   rd_rsp_data,
  output conv_pkg::addr_t        wr_req_addr,
  output conv_pkg::line_t        wr_req_data,
  output logic                   wr_req_en,
  input  wire logic              wr_req_almostfull,
  output logic                   done
);

  conv_pkg::count_t                   job_maps;
  conv_pkg::count_t                   job_filters;
  conv_pkg::addr_t                    job_dest;
  logic                               result_valid;
  conv_pkg::line_t                    result;
  logic [$clog2(`CONV_FIFO_DEPTH):0]  fifo_free;

  buffer_read_if buf_rd ();

  read_requester read_requester_i (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .image_base        (image_base),
    .kernel_base       (kernel_base),
    .dest_base         (dest_base),
    .num_maps          (num_maps),
    .num_filters       (num_filters),
    .rd_req_almostfull (rd_req_almostfull),
    .rd_req_addr       (rd_req_addr),
    .rd_req_tag        (rd_req_tag),
    .rd_req_en         (rd_req_en),
    .job_maps          (job_maps),
    .job_filters       (job_filters),
    .job_dest          (job_dest)
  );

  line_loader line_loader_i (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_tag   (rd_rsp_tag),
    .rd_rsp_data  (rd_rsp_data),
    .job_maps     (job_maps),
    .job_filters  (job_filters),
    .buf_rd       (buf_rd.loader)
  );

  mac_engine mac_engine_i (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .job_maps     (job_maps),
    .job_filters  (job_filters),
    .fifo_free    (fifo_free),
    .buf_rd       (buf_rd.engine),
    .result_valid (result_valid),
    .result       (result)
  );

  write_requester write_requester_i (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .job_dest          (job_dest),
    .job_filters       (job_filters),
    .result_valid      (result_valid),
    .result            (result),
    .wr_req_almostfull (wr_req_almostfull),
    .wr_req_addr       (wr_req_addr),
    .wr_req_data       (wr_req_data),
    .wr_req_en         (wr_req_en),
    .done              (done),
    .fifo_free         (fifo_free)
  );

endmodule

`default_nettype wire

// ==== testbench/conv_accel_assert.sv ====
// protocol checks only; data values are checked by the testbench
`default_nettype none
`timescale 1ns/1ps

module conv_accel_assert (
  input wire logic clk,
  input wire logic reset,
  input wire logic rd_req_en,
  input wire logic rd_req_almostfull,
  input wire logic wr_req_en,
  input wire logic wr_req_almostfull,
  input wire logic result_valid,
  input wire logic done
);

  // number of failed assertions
  int failures = 0;

  // a strobe must follow an edge where almost-full was low
  rd_req_gated: assert property (@(posedge clk) disable iff (reset)
    rd_req_en |-> !$past(rd_req_almostfull))
    else begin
      $error("read request issued while almost-full was high");
      failures++;
    end

  wr_req_gated: assert property (@(posedge clk) disable iff (reset)
    wr_req_en |-> !$past(wr_req_almostfull))
    else begin
      $error("write request issued while almost-full was high");
      failures++;
    end

  done_after_writes: assert property (@(posedge clk) disable iff (reset)
    !(done && wr_req_en))
    else begin
      $error("done high together with a write request");
      failures++;
    end

  // outputs registered at a reset edge must be low
  quiet_in_reset: assert property (@(posedge clk)
    $past(reset) |-> (!rd_req_en && !wr_req_en && !done && !result_valid))
    else begin
      $error("control output high during reset");
      failures++;
    end

endmodule

bind conv_accel_top conv_accel_assert conv_accel_assert_i (
  .clk               (clk),
  .reset             (reset),
  .rd_req_en         (rd_req_en),
  .rd_req_almostfull (rd_req_almostfull),
  .wr_req_en         (wr_req_en),
  .wr_req_almostfull (wr_req_almostfull),
  .result_valid      (result_valid),
  .done              (done)
);

`default_nettype wire

// ==== testbench/tb_conv_accel.sv ====
// runs the two jobs in testbench/conv_testdata.txt; run from the project root
`default_nettype none
`timescale 1ns/1ps

module tb_conv_accel;

  localparam int NUM_JOBS  = 2;
  localparam int WAIT_MAX  = 3000;

  logic clk;
  logic reset;
  logic start;
  conv_pkg::addr_t  image_base;
  conv_pkg::addr_t  kernel_base;
  conv_pkg::addr_t  dest_base;
  conv_pkg::count_t num_maps;
  conv_pkg::count_t num_filters;
  conv_pkg::addr_t  rd_req_addr;
  conv_pkg::tag_t   rd_req_tag;
  logic             rd_req_en;
  logic             rd_req_almostfull;
  logic             rd_rsp_valid;
  conv_pkg::tag_t   rd_rsp_tag;
  conv_pkg::line_t  rd_rsp_data;
  conv_pkg::addr_t  wr_req_addr;
  conv_pkg::line_t  wr_req_data;
  logic             wr_req_en;
  logic             wr_req_almostfull;
  logic             done;

  logic [127:0] tdata [0:31];
  logic [31:0]  rng;
  int           cycle;
  int           job_ptr;
  int           rd_count;
  int           wr_count;
  int           last_due;
  conv_pkg::line_t rsp_data_q [$];
  conv_pkg::tag_t  rsp_tag_q [$];
  int              rsp_due_q [$];

  conv_accel_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_line(input string name, input conv_pkg::line_t got,
                            input conv_pkg::line_t exp);
    if (got !== exp) begin
      abort($sformatf("mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input conv_pkg::addr_t got,
                            input conv_pkg::addr_t exp);
    if (got !== exp) begin
      abort($sformatf("mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_tag(input string name, input conv_pkg::tag_t got,
                           input conv_pkg::tag_t exp);
    if (got !== exp) begin
      abort($sformatf("mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  // memory model and write monitor, called once per falling edge
  task automatic service_bus();
    int k;
    int due;
    k = rd_count;
    if (rd_req_en) begin
      if (k >= num_maps + num_maps * num_filters) begin
        abort("read request beyond the end of the job");
      end
      if (k < num_maps) begin
        check_tag("rd_req_tag", rd_req_tag, conv_pkg::TAG_IMAGE);
        check_addr("rd_req_addr", rd_req_addr, image_base + k);
      end else begin
        check_tag("rd_req_tag", rd_req_tag, conv_pkg::TAG_KERNEL);
        check_addr("rd_req_addr", rd_req_addr, kernel_base + (k - num_maps));
      end
      rng = xorshift(rng);
      due = cycle + 1 + int'(rng % 4);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rsp_data_q.push_back(tdata[job_ptr + 1 + k]);
      rsp_tag_q.push_back(rd_req_tag);
      rsp_due_q.push_back(due);
      rd_count++;
    end
    rd_rsp_valid = 1'b0;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
      rd_rsp_valid = 1'b1;
      rd_rsp_data  = rsp_data_q.pop_front();
      rd_rsp_tag   = rsp_tag_q.pop_front();
      due          = rsp_due_q.pop_front();
    end
    if (wr_req_en) begin
      if (wr_count >= num_filters) begin
        abort("write request beyond the last filter");
      end
      check_addr("wr_req_addr", wr_req_addr, dest_base + wr_count);
      check_line("wr_req_data", wr_req_data,
                 tdata[job_ptr + 1 + num_maps + num_maps * num_filters + wr_count]);
      wr_count++;
    end
    // bursty almost-full on both ports
    rng = xorshift(rng);
    if (rng[1:0] == 2'b00) begin
      rd_req_almostfull = ~rd_req_almostfull;
    end
    if (rng[9:8] == 2'b00) begin
      wr_req_almostfull = ~wr_req_almostfull;
    end
  endtask

  task automatic step();
    @(negedge clk);
    cycle++;
    if (dut_i.conv_accel_assert_i.failures != 0) begin
      abort("a bound protocol assertion failed");
    end
    service_bus();
  endtask

  task automatic run_job();
    logic [127:0] hdr;
    int waited;
    hdr = tdata[job_ptr];
    image_base  = hdr[127:96];
    kernel_base = hdr[95:64];
    dest_base   = hdr[63:32];
    num_maps    = hdr[31:24];
    num_filters = hdr[23:16];
    rd_count    = 0;
    wr_count    = 0;
    start       = 1'b1;
    step();
    start  = 1'b0;
    waited = 0;
    while (!done) begin
      if (waited >= WAIT_MAX) begin
        abort("timeout waiting for done");
      end
      step();
      waited++;
    end
    if (wr_count != num_filters || rd_count != num_maps + num_maps * num_filters) begin
      abort("done rose before all requests of the job were seen");
    end
    // done must hold until the next start
    repeat (6) begin
      step();
      if (!done) begin
        abort("done dropped before the next start");
      end
    end
    job_ptr = job_ptr + 1 + num_maps + num_maps * num_filters + num_filters;
  endtask

  initial begin
    reset             = 1'b1;
    start             = 1'b0;
    image_base        = '0;
    kernel_base       = '0;
    dest_base         = '0;
    num_maps          = '0;
    num_filters       = '0;
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    rd_rsp_valid      = 1'b0;
    rd_rsp_tag        = conv_pkg::TAG_IMAGE;
    rd_rsp_data       = '0;
    rng               = 32'd48;
    cycle             = 0;
    job_ptr           = 0;
    rd_count          = 0;
    wr_count          = 0;
    last_due          = 0;
    $readmemh("testbench/conv_testdata.txt", tdata);
    repeat (3) @(negedge clk);
    reset = 1'b0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job();
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/conv_testdata.txt ====
// per job: header {image_base, kernel_base, dest_base, num_maps, num_filters, 16'h0},
// then image lines, kernel lines (filter-major), expected output lines; lane 0 lowest, re low
00001000000020000000300002030000
000000800000FF000100020000000100
FF000200000003000000010001000000
00000100000001000000010000000100
00000100000001000000010000000100
01000000010000000100000001000000
00000200000002000000020000000200
0000020000000080FF0001000000FF00
00000000000000000000000000000000
FF000280000002000100030001000100
FE800400FF0006000200010003000000
000001000000FF80FF0003000000FF00
000004000000080000000C0001050000
008000800000FE000100000000000100
00000200000002000000020000000200
00000080000000800000008000000080
00000100000001000000010000000100
0000FF000000FF000000FF000000FF00
01000000010000000100000001000000
010001000000FC000200000000000200
004000400000FF000080000000000080
008000800000FE000100000000000100
FF80FF8000000200FF0000000000FF00
0080FF80FE0000000000FF0001000000

// ==== files.f ====
+incdir+source
source/conv_pkg.sv
source/buffer_read_if.sv
source/read_requester.sv
source/line_loader.sv
source/mac_engine.sv
source/write_requester.sv
source/conv_accel_top.sv
testbench/conv_accel_assert.sv
testbench/tb_conv_accel.sv

// ==== Bender.yml ====
package:
  name: conv_accel

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/conv_pkg.sv
      - source/buffer_read_if.sv
      - source/read_requester.sv
      - source/line_loader.sv
      - source/mac_engine.sv
      - source/write_requester.sv
      - source/conv_accel_top.sv
  - target: simulation
    files:
      - testbench/conv_accel_assert.sv
      - testbench/tb_conv_accel.sv
